/* include/nes_glue_macros.svh */
////////////////////
// NES glue constants
// widths, bit positions, expansion audio mappers, autofire period
////////////////////
`ifndef NES_GLUE_MACROS_SVH
`define NES_GLUE_MACROS_SVH

// memory and loader widths
`define NES_ADDR_W      22
`define MAPPER_FLAGS_W  64
`define MAPPER_NUM_W    8   // low field of the mapper flags

// mappers with expansion audio
`define EXT_AUDIO_MAPPER_0  19
`define EXT_AUDIO_MAPPER_1  24
`define EXT_AUDIO_MAPPER_2  26

// SNES buttons that drive autofire on NES A and B
`define BTN_AUTO_A  8
`define BTN_AUTO_B  9

// full autofire cycle in clocks, default for the top parameter
`define AUTOFIRE_PERIOD 16

`endif

/* logic/nes_glue_pkg.sv */
////////////////////
// NES glue types
// shared vector typedefs and the word bridge FSM states
////////////////////
`default_nettype none
`include "nes_glue_macros.svh"

package nes_glue_pkg;

    // NES side
    typedef logic [`NES_ADDR_W-1:0]     nes_addr_t;
    typedef logic [7:0]                 nes_byte_t;
    typedef logic [`MAPPER_FLAGS_W-1:0] mapper_flags_t;

    // R L X A RT LT DN UP START SELECT Y B, low 8 are NES buttons
    typedef logic [11:0] snes_buttons_t;

    // soft CPU bus
    typedef logic [22:0] rv_addr_t;      // byte address
    typedef logic [31:0] rv_word_t;
    typedef logic [3:0]  rv_strb_t;

    // SDRAM half-word port
    typedef logic [15:0] sdram_half_t;
    typedef logic [19:0] sdram_addr_t;   // word address plus half select
    typedef logic [1:0]  byte_sel_t;

    typedef enum logic [2:0] {
        IDLE_REQ0,
        WAIT0_REQ1,
        DATA0,
        WAIT1,
        DATA1
    } rv_state_e;

endpackage

`default_nettype wire

/* logic/nes_run_control.sv */
////////////////////
// NES run control
// holds the console in reset during ROM loads, drives the
// SDRAM clkref phase and latches the new mapper flags
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "nes_glue_macros.svh"

module nes_run_control (
    input  wire                          clk,
    input  wire                          sys_resetn,
    input  wire                          i_loading,
    input  wire                          i_loader_done,
    input  wire nes_glue_pkg::mapper_flags_t i_loader_flags,
    output logic                         o_loader_reset,
    output logic                         o_reset_nes,
    output logic                         o_clkref,
    output nes_glue_pkg::mapper_flags_t  o_mapper_flags,
    output logic                         o_ext_audio
);

    logic                     loading_r;
    logic                     load_start;
    logic                     load_end;
    logic [`MAPPER_NUM_W-1:0] mapper_num;

    assign load_start     = i_loading & ~loading_r;
    assign load_end       = ~i_loading & loading_r;
    assign o_loader_reset = load_start;  // restarts the ROM parser

    ////////////////////
    // reset framing and clkref
    ////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_r   <= 1'b0;
            o_reset_nes <= 1'b1;
            o_clkref    <= 1'b0;
        end else begin
            loading_r <= i_loading;
            o_clkref  <= ~o_clkref;
            if (load_end) begin
                o_reset_nes <= 1'b0;
                o_clkref    <= 1'b1;     // console restarts on a known phase
            end else if (load_start) begin
                o_reset_nes <= 1'b1;
            end
        end
    end

    ////////////////////
    // mapper flags
    ////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            o_mapper_flags <= '0;
        end else if (i_loader_done) begin
            o_mapper_flags <= i_loader_flags;
        end
    end

    assign mapper_num  = o_mapper_flags[`MAPPER_NUM_W-1:0];
    assign o_ext_audio = (mapper_num == `MAPPER_NUM_W'(`EXT_AUDIO_MAPPER_0)) |
                         (mapper_num == `MAPPER_NUM_W'(`EXT_AUDIO_MAPPER_1)) |
                         (mapper_num == `MAPPER_NUM_W'(`EXT_AUDIO_MAPPER_2));

endmodule

`default_nettype wire

/* logic/loader_port.sv */
////////////////////
// loader write port
// holds parser writes, widens the strobe, shares the CPU SDRAM port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module loader_port (
    input  wire                      clk,
    input  wire                      sys_resetn,
    input  wire                      i_loading,
    input  wire                      i_loader_write,
    input  wire nes_glue_pkg::nes_addr_t i_loader_addr,
    input  wire nes_glue_pkg::nes_byte_t i_loader_wdata,
    input  wire nes_glue_pkg::nes_addr_t i_cpu_addr,
    input  wire nes_glue_pkg::nes_byte_t i_cpu_wdata,
    input  wire                      i_cpu_read,
    input  wire                      i_cpu_write,
    output nes_glue_pkg::nes_addr_t  o_mem_addr,
    output nes_glue_pkg::nes_byte_t  o_mem_wdata,
    output logic                     o_mem_we,
    output logic                     o_mem_read
);

    logic                    write_r;
    logic                    we_stretch;   // two cycles per loader write
    nes_glue_pkg::nes_addr_t addr_q;
    nes_glue_pkg::nes_byte_t data_q;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            write_r    <= 1'b0;
            we_stretch <= 1'b0;
        end else begin
            write_r    <= i_loader_write;
            we_stretch <= i_loader_write | write_r;
        end
    end

    always_ff @(posedge clk) begin
        if (i_loader_write) begin
            addr_q <= i_loader_addr;
            data_q <= i_loader_wdata;
        end
    end

    // loader owns the port while loading
    assign o_mem_addr  = i_loading ? addr_q : i_cpu_addr;
    assign o_mem_wdata = i_loading ? data_q : i_cpu_wdata;
    assign o_mem_we    = we_stretch | i_cpu_write;
    assign o_mem_read  = i_cpu_read & ~i_loading;

    // stretched strobe would merge two back-to-back writes
    a_write_spacing: assert property (@(posedge clk) disable iff (!sys_resetn)
        i_loader_write |=> !i_loader_write);

endmodule

`default_nettype wire

/* logic/rv_word_bridge.sv */
////////////////////
// word bridge
// 32-bit valid/ready CPU bus onto the 16-bit toggle req/ack SDRAM port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module rv_word_bridge (
    input  wire                          clk,
    input  wire                          sys_resetn,
    input  wire                          i_rv_valid,
    input  wire nes_glue_pkg::rv_addr_t  i_rv_addr,
    input  wire nes_glue_pkg::rv_word_t  i_rv_wdata,
    input  wire nes_glue_pkg::rv_strb_t  i_rv_wstrb,
    input  wire                          i_sdram_ack,
    input  wire nes_glue_pkg::sdram_half_t i_sdram_rdata,
    output logic                         o_rv_ready,
    output nes_glue_pkg::rv_word_t       o_rv_rdata,
    output logic                         o_sdram_req,
    output nes_glue_pkg::sdram_addr_t    o_sdram_addr,
    output nes_glue_pkg::sdram_half_t    o_sdram_wdata,
    output nes_glue_pkg::byte_sel_t      o_sdram_ds,
    output logic                         o_sdram_we
);

    nes_glue_pkg::rv_state_e   state;
    nes_glue_pkg::sdram_half_t rdata_lo;   // first half of a read
    nes_glue_pkg::byte_sel_t   ds;
    logic                      req;
    logic                      word;       // 0 low half, 1 high half
    logic                      valid_r;
    logic                      pending;    // edge seen while busy
    logic                      start;
    logic                      is_write;
    logic                      done;

    assign start    = i_rv_valid & ~valid_r;
    assign is_write = |i_rv_wstrb;
    assign done     = (req == i_sdram_ack);

    ////////////////////
    // access FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            state      <= nes_glue_pkg::IDLE_REQ0;
            o_rv_ready <= 1'b0;
            req        <= 1'b0;
            word       <= 1'b0;
            ds         <= 2'b11;
            valid_r    <= 1'b0;
            pending    <= 1'b0;
        end else begin
            valid_r    <= i_rv_valid;
            o_rv_ready <= 1'b0;
            if (start)
                pending <= 1'b1;

            case (state)
                nes_glue_pkg::IDLE_REQ0: begin
                    if (pending || start) begin
                        pending <= 1'b0;
                        req     <= ~req;
                        if (is_write && i_rv_wstrb[1:0] == 2'b00) begin
                            word  <= 1'b1;   // high half only
                            ds    <= i_rv_wstrb[3:2];
                            state <= nes_glue_pkg::WAIT1;
                        end else begin
                            word  <= 1'b0;
                            ds    <= is_write ? i_rv_wstrb[1:0] : 2'b11;
                            state <= nes_glue_pkg::WAIT0_REQ1;
                        end
                    end
                end
                nes_glue_pkg::WAIT0_REQ1: begin
                    if (done) begin
                        if (is_write && i_rv_wstrb[3:2] == 2'b00) begin
                            o_rv_ready <= 1'b1;   // low half only
                            state      <= nes_glue_pkg::IDLE_REQ0;
                        end else begin
                            req   <= ~req;
                            word  <= 1'b1;
                            ds    <= is_write ? i_rv_wstrb[3:2] : 2'b11;
                            state <= is_write ? nes_glue_pkg::WAIT1 : nes_glue_pkg::DATA0;
                        end
                    end
                end
                nes_glue_pkg::DATA0: state <= nes_glue_pkg::WAIT1;
                nes_glue_pkg::WAIT1: begin
                    if (done) begin
                        o_rv_ready <= is_write;
                        state      <= is_write ? nes_glue_pkg::IDLE_REQ0 : nes_glue_pkg::DATA1;
                    end
                end
                nes_glue_pkg::DATA1: begin
                    o_rv_ready <= 1'b1;
                    state      <= nes_glue_pkg::IDLE_REQ0;
                end
                default: state <= nes_glue_pkg::IDLE_REQ0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == nes_glue_pkg::DATA0)
            rdata_lo <= i_sdram_rdata;
    end

    assign o_sdram_req   = req;
    assign o_sdram_addr  = {i_rv_addr[20:2], word};
    assign o_sdram_wdata = word ? i_rv_wdata[31:16] : i_rv_wdata[15:0];
    assign o_sdram_ds    = ds;
    assign o_sdram_we    = is_write;
    assign o_rv_rdata    = {i_sdram_rdata, rdata_lo};   // upper half read live

    a_ready_pulse: assert property (@(posedge clk) disable iff (!sys_resetn)
        o_rv_ready |=> !o_rv_ready);

    // no SDRAM access may be outstanding once idle
    a_idle_settled: assert property (@(posedge clk) disable iff (!sys_resetn)
        state == nes_glue_pkg::IDLE_REQ0 |-> i_sdram_ack == req);

endmodule

`default_nettype wire

/* logic/autofire.sv */
////////////////////
// autofire
// square wave while a button is held
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "nes_glue_macros.svh"

module autofire #(
    parameter int PERIOD = `AUTOFIRE_PERIOD
) (
    input  wire  clk,
    input  wire  sys_resetn,
    input  wire  i_btn,
    output logic o_fire
);

    localparam int CNT_W = $clog2(PERIOD);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!sys_resetn || !i_btn) begin
            cnt    <= '0;
            o_fire <= 1'b0;
        end else begin
            cnt    <= (cnt == CNT_W'(PERIOD - 1)) ? '0 : cnt + 1'b1;
            o_fire <= (cnt < CNT_W'(PERIOD / 2));   // first half of the period
        end
    end

endmodule

`default_nettype wire

/* logic/joypad_port.sv */
////////////////////
// NES joypad port
// parallel-in serial-out controller register with autofire on A and B
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "nes_glue_macros.svh"

module joypad_port #(
    parameter int AUTOFIRE_PERIOD = `AUTOFIRE_PERIOD
) (
    input  wire                            clk,
    input  wire                            sys_resetn,
    input  wire nes_glue_pkg::snes_buttons_t i_buttons,
    input  wire                            i_strobe,
    input  wire                            i_joy_clk,
    output logic                           o_joy_data
);

    nes_glue_pkg::nes_byte_t bits;
    logic                    joy_clk_r;
    logic                    clk_fall;
    logic                    auto_a;
    logic                    auto_b;

    autofire #(.PERIOD(AUTOFIRE_PERIOD)) af_a (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .i_btn      (i_buttons[`BTN_AUTO_A]),
        .o_fire     (auto_a)
    );

    autofire #(.PERIOD(AUTOFIRE_PERIOD)) af_b (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .i_btn      (i_buttons[`BTN_AUTO_B]),
        .o_fire     (auto_b)
    );

    assign clk_fall = ~i_joy_clk & joy_clk_r;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            bits      <= '0;
            joy_clk_r <= 1'b0;
        end else begin
            joy_clk_r <= i_joy_clk;
            if (i_strobe)
                bits <= {i_buttons[7:2], i_buttons[1] | auto_b, i_buttons[0] | auto_a};
            if (clk_fall)
                bits <= {1'b1, bits[7:1]};   // 1s after the eighth bit
        end
    end

    assign o_joy_data = bits[0];

    a_bits_known: assert property (@(posedge clk) disable iff (!sys_resetn)
        !$isunknown(bits));

endmodule

`default_nettype wire

/* logic/nes_glue_top.sv */
////////////////////
// NES board glue top
// run control, loader port, word bridge and two joypad ports
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "nes_glue_macros.svh"

module nes_glue_top #(
    parameter int AUTOFIRE_PERIOD = `AUTOFIRE_PERIOD
) (
    input  wire                            clk,
    input  wire                            sys_resetn,
    // run control
    input  wire                            i_loading,
    input  wire                            i_loader_done,
    input  wire nes_glue_pkg::mapper_flags_t i_loader_flags,
    output logic                           o_loader_reset,
    output logic                           o_reset_nes,
    output logic                           o_clkref,
    output nes_glue_pkg::mapper_flags_t    o_mapper_flags,
    output logic                           o_ext_audio,
    // loader and CPU memory port
    input  wire                            i_loader_write,
    input  wire nes_glue_pkg::nes_addr_t   i_loader_addr,
    input  wire nes_glue_pkg::nes_byte_t   i_loader_wdata,
    input  wire nes_glue_pkg::nes_addr_t   i_cpu_addr,
    input  wire nes_glue_pkg::nes_byte_t   i_cpu_wdata,
    input  wire                            i_cpu_read,
    input  wire                            i_cpu_write,
    output nes_glue_pkg::nes_addr_t        o_mem_addr,
    output nes_glue_pkg::nes_byte_t        o_mem_wdata,
    output logic                           o_mem_we,
    output logic                           o_mem_read,
    // soft CPU bus and SDRAM half-word port
    input  wire                            i_rv_valid,
    input  wire nes_glue_pkg::rv_addr_t    i_rv_addr,
    input  wire nes_glue_pkg::rv_word_t    i_rv_wdata,
    input  wire nes_glue_pkg::rv_strb_t    i_rv_wstrb,
    output logic                           o_rv_ready,
    output nes_glue_pkg::rv_word_t         o_rv_rdata,
    input  wire                            i_sdram_ack,
    input  wire nes_glue_pkg::sdram_half_t i_sdram_rdata,
    output logic                           o_sdram_req,
    output nes_glue_pkg::sdram_addr_t      o_sdram_addr,
    output nes_glue_pkg::sdram_half_t      o_sdram_wdata,
    output nes_glue_pkg::byte_sel_t        o_sdram_ds,
    output logic                           o_sdram_we,
    // joypads
    input  wire nes_glue_pkg::snes_buttons_t i_joy1_buttons,
    input  wire nes_glue_pkg::snes_buttons_t i_joy2_buttons,
    input  wire                            i_joypad_strobe,
    input  wire [1:0]                      i_joypad_clock,
    output logic                           o_joypad1_data,
    output logic                           o_joypad2_data
);

    nes_run_control run_ctrl (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_loading(i_loading), .i_loader_done(i_loader_done),
        .i_loader_flags(i_loader_flags), .o_loader_reset(o_loader_reset),
        .o_reset_nes(o_reset_nes), .o_clkref(o_clkref),
        .o_mapper_flags(o_mapper_flags), .o_ext_audio(o_ext_audio)
    );

    loader_port ldr_port (
        .clk(clk), .sys_resetn(sys_resetn), .i_loading(i_loading),
        .i_loader_write(i_loader_write), .i_loader_addr(i_loader_addr),
        .i_loader_wdata(i_loader_wdata), .i_cpu_addr(i_cpu_addr),
        .i_cpu_wdata(i_cpu_wdata), .i_cpu_read(i_cpu_read), .i_cpu_write(i_cpu_write),
        .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
        .o_mem_we(o_mem_we), .o_mem_read(o_mem_read)
    );

    rv_word_bridge rv_bridge (
        .clk(clk), .sys_resetn(sys_resetn),
        .i_rv_valid(i_rv_valid), .i_rv_addr(i_rv_addr), .i_rv_wdata(i_rv_wdata),
        .i_rv_wstrb(i_rv_wstrb), .i_sdram_ack(i_sdram_ack), .i_sdram_rdata(i_sdram_rdata),
        .o_rv_ready(o_rv_ready), .o_rv_rdata(o_rv_rdata), .o_sdram_req(o_sdram_req),
        .o_sdram_addr(o_sdram_addr), .o_sdram_wdata(o_sdram_wdata),
        .o_sdram_ds(o_sdram_ds), .o_sdram_we(o_sdram_we)
    );

    // one port per controller, clock bit 0 for pad 1
    joypad_port #(.AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)) joy1 (
        .clk(clk), .sys_resetn(sys_resetn), .i_buttons(i_joy1_buttons),
        .i_strobe(i_joypad_strobe), .i_joy_clk(i_joypad_clock[0]),
        .o_joy_data(o_joypad1_data)
    );

    joypad_port #(.AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)) joy2 (
        .clk(clk), .sys_resetn(sys_resetn), .i_buttons(i_joy2_buttons),
        .i_strobe(i_joypad_strobe), .i_joy_clk(i_joypad_clock[1]),
        .o_joy_data(o_joypad2_data)
    );

endmodule

`default_nettype wire

/* test/nes_glue_tb.sv */
////////////////////
// NES glue testbench
// table driven checks of the top level with a half-word SDRAM model
////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "nes_glue_macros.svh"

module nes_glue_tb;

    localparam int K_LOAD    = 0;
    localparam int K_LDWR    = 1;
    localparam int K_CPU     = 2;
    localparam int K_MAPPER  = 3;
    localparam int K_RVWR    = 4;
    localparam int K_RVRD    = 5;
    localparam int K_JOY     = 6;
    localparam int K_AF_HOLD = 7;
    localparam int K_AF_REL  = 8;
    localparam nes_glue_pkg::rv_addr_t RV_ADDR = 23'h01a2c4;

    logic clk = 1'b0;
    logic sys_resetn;
    logic i_loading, i_loader_done, i_loader_write, i_cpu_read, i_cpu_write;
    logic o_loader_reset, o_reset_nes, o_clkref, o_ext_audio, o_mem_we, o_mem_read;
    logic i_rv_valid, o_rv_ready, o_sdram_req, o_sdram_we;
    logic i_sdram_ack = 1'b0;                    // driven by the SDRAM model only
    logic i_joypad_strobe, o_joypad1_data, o_joypad2_data;
    logic [1:0]                  i_joypad_clock;
    nes_glue_pkg::mapper_flags_t i_loader_flags, o_mapper_flags;
    nes_glue_pkg::nes_addr_t     i_loader_addr, i_cpu_addr, o_mem_addr;
    nes_glue_pkg::nes_byte_t     i_loader_wdata, i_cpu_wdata, o_mem_wdata;
    nes_glue_pkg::rv_addr_t      i_rv_addr;
    nes_glue_pkg::rv_word_t      i_rv_wdata, o_rv_rdata;
    nes_glue_pkg::rv_strb_t      i_rv_wstrb;
    nes_glue_pkg::sdram_half_t   i_sdram_rdata = 16'h0000;
    nes_glue_pkg::sdram_half_t   o_sdram_wdata;
    nes_glue_pkg::sdram_addr_t   o_sdram_addr;
    nes_glue_pkg::byte_sel_t     o_sdram_ds;
    nes_glue_pkg::snes_buttons_t i_joy1_buttons, i_joy2_buttons;

    // test table with one entry per row in each queue
    string       row_name[$];
    int          row_kind[$];
    logic [63:0] row_stim[$];
    logic [31:0] row_aux[$];
    logic [63:0] row_exp[$];
    int          n_rows = 0;

    int          checks = 0;
    int          errors = 0;
    int          seed = 32'h3491a4f7;
    logic [15:0] mem [int];      // sparse SDRAM contents
    logic        m_busy = 1'b0;
    int          m_wait = 0;
    int          req_count = 0;  // toggle requests seen
    logic [31:0] ref_word;       // expected word at RV_ADDR

    always #2 clk = ~clk;

    nes_glue_top dut0 (.*);

    function automatic logic [15:0] fill_half(input logic [19:0] a);
        return a[15:0] ^ {a[19:16], a[11:0]} ^ 16'hc35a;
    endfunction

    ////////////////////
    // SDRAM model
    ////////////////////
    always @(negedge clk) begin
        logic [15:0] half;
        if (m_busy) begin
            if (m_wait == 0) begin
                half = mem.exists(int'(o_sdram_addr)) ? mem[int'(o_sdram_addr)]
                                                      : fill_half(o_sdram_addr);
                if (o_sdram_we) begin
                    if (o_sdram_ds[0])
                        half[7:0] = o_sdram_wdata[7:0];
                    if (o_sdram_ds[1])
                        half[15:8] = o_sdram_wdata[15:8];
                    mem[int'(o_sdram_addr)] = half;
                end else begin
                    i_sdram_rdata = half;
                end
                i_sdram_ack = o_sdram_req;   // access complete
                m_busy      = 1'b0;
            end else begin
                m_wait = m_wait - 1;
            end
        end else if (o_sdram_req != i_sdram_ack) begin
            m_busy    = 1'b1;
            m_wait    = $unsigned($random(seed)) % 6;
            req_count = req_count + 1;
        end
    end

    task automatic add_row(input string name, input int kind, input logic [63:0] stim,
                           input logic [31:0] aux, input logic [63:0] exp);
        row_name.push_back(name);
        row_kind.push_back(kind);
        row_stim.push_back(stim);
        row_aux.push_back(aux);
        row_exp.push_back(exp);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    // polls just after each falling edge
    task automatic wait_ready(input string name);
        int n = 0;
        while (o_rv_ready !== 1'b1 && n < 100) begin
            @(negedge clk);
            #1;
            n++;
        end
        assert (o_rv_ready === 1'b1) else begin
            errors++;
            $display("%s: the bridge never answered with o_rv_ready", name);
        end
    endtask

    ////////////////////
    // row execution
    ////////////////////
    task automatic apply_row(input int r);
        string       name;
        logic [63:0] a;
        logic [31:0] b;
        logic [63:0] e;
        logic [11:0] pat1;
        logic [11:0] pat2;
        logic [1:0]  seen;
        int          count;
        name = row_name[r];
        a    = row_stim[r];
        b    = row_aux[r];
        e    = row_exp[r];
        count = 0;
        @(negedge clk);
        case (row_kind[r])
            K_LOAD: begin
                i_loading = 1'b1;
                for (int c = 0; c < 4; c++) begin
                    #1;
                    if (o_loader_reset)
                        count++;
                    @(negedge clk);
                end
                // drop on a high clkref so the forced phase differs from a toggle
                if (o_clkref !== 1'b1)
                    @(negedge clk);
                i_loading = 1'b0;
                #1;
                check_value({name, "_nes_held"}, 64'd1, 64'(o_reset_nes));
                @(negedge clk);
                #1;
                check_value({name, "_nes_run"}, 64'd0, 64'(o_reset_nes));
                check_value({name, "_clkref_forced"}, 64'd1, 64'(o_clkref));
                @(negedge clk);
                #1;
                check_value({name, "_clkref_low"}, 64'd0, 64'(o_clkref));
                @(negedge clk);
                #1;
                check_value({name, "_clkref_high"}, 64'd1, 64'(o_clkref));
                check_value({name, "_reset_pulses"}, e, 64'(count));
            end
            K_LDWR: begin
                i_loading      = 1'b1;
                i_loader_write = 1'b1;
                i_loader_addr  = a[29:8];
                i_loader_wdata = a[7:0];
                @(negedge clk);
                i_loader_write = 1'b0;
                i_loader_addr  = ~a[29:8];   // captured copy must hold
                for (int c = 0; c < 4; c++) begin
                    #1;
                    if (o_mem_we)
                        count++;
                    if (c == 0) begin
                        check_value({name, "_addr"}, 64'(a[29:8]), 64'(o_mem_addr));
                        check_value({name, "_data"}, 64'(a[7:0]), 64'(o_mem_wdata));
                        check_value({name, "_nes_held"}, 64'd1, 64'(o_reset_nes));
                    end
                    @(negedge clk);
                end
                check_value({name, "_we_cycles"}, e, 64'(count));
            end
            K_CPU: begin
                i_loading   = 1'b0;
                i_cpu_addr  = a[29:8];
                i_cpu_wdata = a[7:0];
                i_cpu_read  = 1'b1;
                #1;
                check_value({name, "_addr"}, 64'(a[29:8]), 64'(o_mem_addr));
                check_value({name, "_data"}, 64'(a[7:0]), 64'(o_mem_wdata));
                check_value({name, "_read"}, e, 64'(o_mem_read));
                @(negedge clk);
                i_cpu_read = 1'b0;
                #1;
                check_value({name, "_read_off"}, 64'd0, 64'(o_mem_read));
            end
            K_MAPPER: begin
                i_loader_flags = a;
                i_loader_done  = 1'b1;
                @(negedge clk);
                i_loader_done  = 1'b0;
                i_loader_flags = '0;
                #1;
                check_value({name, "_flags"}, a, o_mapper_flags);
                check_value({name, "_ext_audio"}, e, 64'(o_ext_audio));
            end
            K_RVWR, K_RVRD: begin
                i_rv_addr  = RV_ADDR;
                i_rv_wdata = a[31:0];
                i_rv_wstrb = b[3:0];
                i_rv_valid = 1'b1;
                count      = req_count;
                #1;
                wait_ready(name);
                if (row_kind[r] == K_RVRD)
                    check_value({name, "_rdata"}, 64'(ref_word), 64'(o_rv_rdata));
                for (int i = 0; i < 4; i++) begin
                    if (b[i])
                        ref_word[8*i +: 8] = a[8*i +: 8];   // strobed bytes only
                end
                @(negedge clk);
                i_rv_valid = 1'b0;
                check_value({name, "_requests"}, e, 64'(req_count - count));
            end
            K_JOY: begin
                pat1            = a[11:0];
                pat2            = a[11:0] ^ 12'h0ff;
                i_joy1_buttons  = pat1;
                i_joy2_buttons  = pat2;
                i_joypad_strobe = 1'b1;
                @(negedge clk);
                i_joypad_strobe = 1'b0;
                for (int i = 0; i < 10; i++) begin
                    #1;
                    check_value($sformatf("%s_pad1_bit%0d", name, i),
                                64'((i < 8) ? pat1[i] : 1'b1), 64'(o_joypad1_data));
                    check_value($sformatf("%s_pad2_bit%0d", name, i),
                                64'((i < 8) ? pat2[i] : 1'b1), 64'(o_joypad2_data));
                    @(negedge clk);
                    i_joypad_clock = 2'b11;
                    @(negedge clk);
                    i_joypad_clock = 2'b00;   // shift on this fall
                    @(negedge clk);
                end
            end
            K_AF_HOLD: begin
                seen           = 2'b00;
                i_joy1_buttons = a[11:0];
                // 3-cycle steps walk through every phase of the period
                for (int k = 0; k < `AUTOFIRE_PERIOD; k++) begin
                    @(negedge clk);
                    i_joypad_strobe = 1'b1;
                    @(negedge clk);
                    i_joypad_strobe = 1'b0;
                    #1;
                    seen[o_joypad1_data] = 1'b1;
                    @(negedge clk);
                end
                check_value({name, "_levels_seen"}, e, 64'(seen));
            end
            K_AF_REL: begin
                i_joy1_buttons = a[11:0];
                @(negedge clk);
                i_joypad_strobe = 1'b1;
                @(negedge clk);
                i_joypad_strobe = 1'b0;
                #1;
                check_value({name, "_first_bit"}, e, 64'(o_joypad1_data));
            end
            default: begin
                errors++;
                $display("%s: the table holds an unknown operation", name);
            end
        endcase
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        sys_resetn      = 1'b0;
        i_loading       = 1'b0;
        i_loader_done   = 1'b0;
        i_loader_flags  = '0;
        i_loader_write  = 1'b0;
        i_loader_addr   = '0;
        i_loader_wdata  = '0;
        i_cpu_addr      = 22'h3c0ffe;
        i_cpu_wdata     = 8'h5e;
        i_cpu_read      = 1'b0;
        i_cpu_write     = 1'b0;
        i_rv_valid      = 1'b0;
        i_rv_addr       = '0;
        i_rv_wdata      = '0;
        i_rv_wstrb      = '0;
        i_joy1_buttons  = '0;
        i_joy2_buttons  = '0;
        i_joypad_strobe = 1'b0;
        i_joypad_clock  = 2'b00;
        ref_word = {fill_half({RV_ADDR[20:2], 1'b1}), fill_half({RV_ADDR[20:2], 1'b0})};

        add_row("load_framing", K_LOAD, 64'h0, 32'h0, 64'd1);
        add_row("loader_write_a", K_LDWR, {34'h0, 22'h000123, 8'ha5}, 32'h0, 64'd2);
        add_row("loader_write_b", K_LDWR, {34'h0, 22'h2fedc0, 8'h3c}, 32'h0, 64'd2);
        add_row("cpu_port", K_CPU, {34'h0, 22'h155aa3, 8'h69}, 32'h0, 64'd1);
        add_row("mapper_4", K_MAPPER, 64'h0000_00f0_1200_0004, 32'h0, 64'd0);
        add_row("mapper_19", K_MAPPER, 64'h8000_0000_0001_0013, 32'h0, 64'd1);
        add_row("mapper_24", K_MAPPER, 64'h0000_0300_0000_0018, 32'h0, 64'd1);
        add_row("mapper_26", K_MAPPER, 64'h0123_4567_89ab_001a, 32'h0, 64'd1);
        add_row("mapper_0", K_MAPPER, 64'hffff_ffff_ffff_ff00, 32'h0, 64'd0);
        add_row("rv_write_full", K_RVWR, 64'h0000_0000_dead_beef, 32'hf, 64'd2);
        add_row("rv_read_full", K_RVRD, 64'h0, 32'h0, 64'd2);
        add_row("rv_write_low", K_RVWR, 64'h0000_0000_1234_5678, 32'h3, 64'd1);
        add_row("rv_read_low", K_RVRD, 64'h0, 32'h0, 64'd2);
        add_row("rv_write_high", K_RVWR, 64'h0000_0000_9abc_def0, 32'hc, 64'd1);
        add_row("rv_read_high", K_RVRD, 64'h0, 32'h0, 64'd2);
        add_row("joy_pattern_a", K_JOY, 64'hc5a, 32'h0, 64'd0);
        add_row("joy_pattern_b", K_JOY, 64'h4f0, 32'h0, 64'd0);
        add_row("joy_pattern_c", K_JOY, 64'h801, 32'h0, 64'd0);
        add_row("autofire_hold", K_AF_HOLD, 64'h100, 32'h0, 64'h3);
        add_row("autofire_release", K_AF_REL, 64'h000, 32'h0, 64'h0);
        n_rows = row_name.size();

        repeat (3) @(negedge clk);
        sys_resetn = 1'b1;
        @(negedge clk);
        #1;
        check_value("reset_nes_after_reset", 64'd1, 64'(o_reset_nes));
        check_value("ready_after_reset", 64'd0, 64'(o_rv_ready));

        for (int r = 0; r < n_rows; r++)
            apply_row(r);

        repeat (4) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog of 200 cycles per table row
    initial begin
        wait (n_rows > 0);
        repeat (n_rows * 200) @(posedge clk);
        $display("watchdog expired after %0d cycles, checks %0d, errors %0d",
                 n_rows * 200, checks, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
logic/nes_glue_pkg.sv
logic/nes_run_control.sv
logic/loader_port.sv
logic/rv_word_bridge.sv
logic/autofire.sv
logic/joypad_port.sv
logic/nes_glue_top.sv
test/nes_glue_tb.sv

/* Makefile */
# Verilator build and run of the NES glue testbench

VERILATOR ?= verilator
TOP       ?= nes_glue_tb
FLAGS     ?= --assert --timescale 1ns/1ps
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLAGS OBJ_DIR"

test:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f verilog.f --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
